/* hdl/mem_bus_pkg.sv */
package mem_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus field widths
    ////////////////////////////////////////////////////////////////////////////

    // response and tag fields, zero means no tag
    localparam int MEM_TAG_W = 4;

    // one memory block, two instruction words
    localparam int MEM_BLOCK_W = 64;

    // byte offset bits inside a block
    localparam int MEM_OFFSET_W = 3;

    ////////////////////////////////////////////////////////////////////////////
    // bus encodings
    ////////////////////////////////////////////////////////////////////////////

    // command driven to memory
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_t;

    // access size, only double is used here
    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_t;

    // side holding the outstanding load
    typedef enum logic [1:0] {
        OWNER_NONE = 2'h0,
        OWNER_DATA = 2'h1,
        OWNER_INST = 2'h2
    } mem_owner_t;

endpackage

/* hdl/core_pkg.sv */
package core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // core widths
    ////////////////////////////////////////////////////////////////////////////

    // address and data word
    localparam int XLEN = 32;

    // one instruction
    localparam int INST_W = 32;

    ////////////////////////////////////////////////////////////////////////////
    // program counter
    ////////////////////////////////////////////////////////////////////////////

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // sequential advance, no branches in this front end
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

endpackage

/* hdl/fetch_stage.sv */
module fetch_stage (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              fetch_grant,
    input  logic                              fetch_reply,
    input  logic [mem_bus_pkg::MEM_BLOCK_W-1:0] reply_block,
    output logic                              fetch_request,
    output logic [core_pkg::XLEN-1:0]         fetch_addr,
    output logic                              if_valid,
    output logic [core_pkg::XLEN-1:0]         if_pc,
    output logic [core_pkg::INST_W-1:0]       if_inst
);

    // start holds the request off for one cycle after reset
    typedef enum logic [1:0] {
        FETCH_START   = 2'h0,
        FETCH_REQUEST = 2'h1,
        FETCH_WAIT    = 2'h2
    } fetch_state_t;

    fetch_state_t                  state_q;
    logic [core_pkg::XLEN-1:0]     pc_q;
    logic [core_pkg::INST_W-1:0]   selected_inst;

    ////////////////////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////////////////////

    // level request until the arbiter grants it
    assign fetch_request = (state_q == FETCH_REQUEST);

    // block aligned, low offset bits dropped
    assign fetch_addr = {pc_q[core_pkg::XLEN-1:mem_bus_pkg::MEM_OFFSET_W],
                         {mem_bus_pkg::MEM_OFFSET_W{1'b0}}};

    // pc bit 2 picks the upper or lower word of the block
    assign selected_inst = pc_q[2] ? reply_block[2*core_pkg::INST_W-1:core_pkg::INST_W]
                                   : reply_block[core_pkg::INST_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // pc and pending state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_q  <= FETCH_START;
            pc_q     <= core_pkg::RESET_PC;
            if_valid <= 1'b0;
        end else begin
            // pulse only in the cycle after the reply
            if_valid <= fetch_reply;
            case (state_q)
                FETCH_START: begin
                    state_q <= FETCH_REQUEST;
                end
                FETCH_REQUEST: begin
                    // memory took it, now wait for the tagged reply
                    if (fetch_grant) begin
                        state_q <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (fetch_reply) begin
                        state_q <= FETCH_REQUEST;
                        pc_q    <= pc_q + core_pkg::PC_STEP;
                    end
                end
                default: begin
                    state_q <= FETCH_START;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////////////////////////////////////////

    // payload only, qualified by if_valid
    always_ff @(posedge clock) begin
        if (fetch_reply) begin
            if_pc   <= pc_q;
            if_inst <= selected_inst;
        end
    end

    // arbiter routes a reply here only for a fetch we are waiting on
    a_reply_needs_pending : assert property (
        @(posedge clock) disable iff (reset)
        fetch_reply |-> (state_q == FETCH_WAIT)
    );

endmodule

/* hdl/mem_arbiter.sv */
module mem_arbiter (
    input  logic                                clock,
    input  logic                                reset,
    // fetch side
    input  logic                                fetch_request,
    input  logic [core_pkg::XLEN-1:0]           fetch_addr,
    output logic                                fetch_grant,
    output logic                                fetch_reply,
    output logic [mem_bus_pkg::MEM_BLOCK_W-1:0] reply_block,
    // data side
    input  mem_bus_pkg::bus_command_t           dmem_command,
    input  logic [core_pkg::XLEN-1:0]           dmem_addr,
    input  logic [mem_bus_pkg::MEM_BLOCK_W-1:0] dmem_wdata,
    output logic                                dmem_grant,
    output logic                                dmem_valid,
    output logic [mem_bus_pkg::MEM_BLOCK_W-1:0] dmem_data,
    // memory port
    input  logic [mem_bus_pkg::MEM_TAG_W-1:0]   mem2proc_response,
    input  logic [mem_bus_pkg::MEM_BLOCK_W-1:0] mem2proc_data,
    input  logic [mem_bus_pkg::MEM_TAG_W-1:0]   mem2proc_tag,
    output mem_bus_pkg::bus_command_t           proc2mem_command,
    output logic [core_pkg::XLEN-1:0]           proc2mem_addr,
    output logic [mem_bus_pkg::MEM_BLOCK_W-1:0] proc2mem_data,
    output mem_bus_pkg::mem_size_t              proc2mem_size
);

    mem_bus_pkg::mem_owner_t                owner_q;
    logic [mem_bus_pkg::MEM_TAG_W-1:0]      tag_q;
    logic                                   idle;
    logic                                   data_select;
    logic                                   accepted;
    logic                                   tag_match;

    ////////////////////////////////////////////////////////////////////////////
    // request selection
    ////////////////////////////////////////////////////////////////////////////

    assign idle = (owner_q == mem_bus_pkg::OWNER_NONE);

    // data side wins over fetch
    assign data_select = (dmem_command != mem_bus_pkg::BUS_NONE);

    always_comb begin
        proc2mem_command = mem_bus_pkg::BUS_NONE;
        proc2mem_addr    = fetch_addr;
        // store data only matters on a store
        proc2mem_data    = dmem_wdata;
        proc2mem_size    = mem_bus_pkg::DOUBLE;
        // nothing goes out while a load is outstanding
        if (idle) begin
            if (data_select) begin
                proc2mem_command = dmem_command;
                proc2mem_addr    = dmem_addr;
            end else if (fetch_request) begin
                proc2mem_command = mem_bus_pkg::BUS_LOAD;
            end
        end
    end

    // non-zero response is the accepted tag
    assign accepted = (proc2mem_command != mem_bus_pkg::BUS_NONE)
                   && (mem2proc_response != '0);

    // grant is memory's acceptance, same cycle
    assign dmem_grant  = accepted && data_select;
    assign fetch_grant = accepted && !data_select;

    ////////////////////////////////////////////////////////////////////////////
    // owner and tag record
    ////////////////////////////////////////////////////////////////////////////

    // zero tag never matches
    assign tag_match = (mem2proc_tag != '0) && (mem2proc_tag == tag_q);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            owner_q <= mem_bus_pkg::OWNER_NONE;
            tag_q   <= '0;
        end else if (tag_match) begin
            // reply consumed, back to idle
            owner_q <= mem_bus_pkg::OWNER_NONE;
            tag_q   <= '0;
        end else if (accepted && proc2mem_command == mem_bus_pkg::BUS_LOAD) begin
            owner_q <= data_select ? mem_bus_pkg::OWNER_DATA : mem_bus_pkg::OWNER_INST;
            tag_q   <= mem2proc_response;
        end
        // a store finishes on acceptance, owner stays none
    end

    ////////////////////////////////////////////////////////////////////////////
    // reply routing
    ////////////////////////////////////////////////////////////////////////////

    // block goes to both sides, the pulse says whose it is
    assign dmem_data   = mem2proc_data;
    assign reply_block = mem2proc_data;

    assign dmem_valid  = tag_match && (owner_q == mem_bus_pkg::OWNER_DATA);
    assign fetch_reply = tag_match && (owner_q == mem_bus_pkg::OWNER_INST);

    // one transaction in flight at a time
    a_no_command_while_busy : assert property (
        @(posedge clock) disable iff (reset)
        (owner_q != mem_bus_pkg::OWNER_NONE) |-> (proc2mem_command == mem_bus_pkg::BUS_NONE)
    );

    // tag record and owner record stay in step across the transaction
    a_match_has_owner : assert property (
        @(posedge clock) disable iff (reset)
        tag_match |-> (owner_q != mem_bus_pkg::OWNER_NONE)
    );

endmodule

/* hdl/pipeline_front.sv */
module pipeline_front (
    input  logic                                clock,
    input  logic                                reset,
    // memory port
    input  logic [mem_bus_pkg::MEM_TAG_W-1:0]   mem2proc_response,
    input  logic [mem_bus_pkg::MEM_BLOCK_W-1:0] mem2proc_data,
    input  logic [mem_bus_pkg::MEM_TAG_W-1:0]   mem2proc_tag,
    output mem_bus_pkg::bus_command_t           proc2mem_command,
    output logic [core_pkg::XLEN-1:0]           proc2mem_addr,
    output logic [mem_bus_pkg::MEM_BLOCK_W-1:0] proc2mem_data,
    output mem_bus_pkg::mem_size_t              proc2mem_size,
    // data request port, stands in for the load/store queue
    input  mem_bus_pkg::bus_command_t           dmem_command,
    input  logic [core_pkg::XLEN-1:0]           dmem_addr,
    input  logic [mem_bus_pkg::MEM_BLOCK_W-1:0] dmem_wdata,
    output logic                                dmem_grant,
    output logic                                dmem_valid,
    output logic [mem_bus_pkg::MEM_BLOCK_W-1:0] dmem_data,
    // IF/ID register
    output logic                                if_valid,
    output logic [core_pkg::XLEN-1:0]           if_pc,
    output logic [core_pkg::INST_W-1:0]         if_inst
);

    ////////////////////////////////////////////////////////////////////////////
    // fetch to arbiter
    ////////////////////////////////////////////////////////////////////////////

    logic                                fetch_request;
    logic [core_pkg::XLEN-1:0]           fetch_addr;
    logic                                fetch_grant;
    logic                                fetch_reply;
    logic [mem_bus_pkg::MEM_BLOCK_W-1:0] reply_block;

    fetch_stage fetch_stage_0 (
        .clock         (clock),
        .reset         (reset),
        .fetch_grant   (fetch_grant),
        .fetch_reply   (fetch_reply),
        .reply_block   (reply_block),
        .fetch_request (fetch_request),
        .fetch_addr    (fetch_addr),
        .if_valid      (if_valid),
        .if_pc         (if_pc),
        .if_inst       (if_inst)
    );

    // single shared memory port
    mem_arbiter mem_arbiter_0 (
        .clock             (clock),
        .reset             (reset),
        .fetch_request     (fetch_request),
        .fetch_addr        (fetch_addr),
        .fetch_grant       (fetch_grant),
        .fetch_reply       (fetch_reply),
        .reply_block       (reply_block),
        .dmem_command      (dmem_command),
        .dmem_addr         (dmem_addr),
        .dmem_wdata        (dmem_wdata),
        .dmem_grant        (dmem_grant),
        .dmem_valid        (dmem_valid),
        .dmem_data         (dmem_data),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .proc2mem_size     (proc2mem_size)
    );

endmodule

/* dv/mem_model.sv */
module mem_model (
    input  logic                                clock,
    input  logic                                reset,
    // chance in percent that a request is refused this cycle
    input  int                                  refuse_percent,
    input  mem_bus_pkg::bus_command_t           proc2mem_command,
    input  logic [core_pkg::XLEN-1:0]           proc2mem_addr,
    input  logic [mem_bus_pkg::MEM_BLOCK_W-1:0] proc2mem_data,
    output logic [mem_bus_pkg::MEM_TAG_W-1:0]   mem2proc_response,
    output logic [mem_bus_pkg::MEM_BLOCK_W-1:0] mem2proc_data,
    output logic [mem_bus_pkg::MEM_TAG_W-1:0]   mem2proc_tag
);
    timeunit 1ns;
    timeprecision 1ps;

    // load reply latency in cycles after acceptance
    localparam int LATENCY_MIN  = 2;
    localparam int LATENCY_SPAN = 5;

    int seed = 29107;

    // written blocks only, keyed by block index
    logic [mem_bus_pkg::MEM_BLOCK_W-1:0] blocks [logic [28:0]];

    logic                                pending;
    logic [mem_bus_pkg::MEM_TAG_W-1:0]   pending_tag;
    logic [core_pkg::XLEN-1:0]           pending_addr;
    logic [mem_bus_pkg::MEM_TAG_W-1:0]   next_tag;
    int                                  countdown;
    int                                  roll;

    // contents of a block nobody wrote, mixes every address bit
    function automatic logic [63:0] fill_block(input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] lo;
        logic [31:0] hi;
        base = {addr[31:3], 3'b000};
        lo   = (base * 32'h9E37_79B9) ^ 32'h1357_9BDF;
        hi   = ((base + 32'd4) * 32'h9E37_79B9) ^ 32'h2468_ACE0;
        return {hi, lo};
    endfunction

    function automatic logic [63:0] read_block(input logic [31:0] addr);
        if (blocks.exists(addr[31:3])) begin
            return blocks[addr[31:3]];
        end
        return fill_block(addr);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // accept, store and reply
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            mem2proc_response <= '0;
            mem2proc_data     <= '0;
            mem2proc_tag      <= '0;
            pending   = 1'b0;
            next_tag  = 4'd1;
            countdown = 0;
        end else begin
            // reply tag is a one cycle pulse
            mem2proc_tag <= '0;
            if (pending) begin
                countdown = countdown - 1;
                if (countdown == 0) begin
                    mem2proc_tag  <= pending_tag;
                    mem2proc_data <= read_block(pending_addr);
                    pending = 1'b0;
                end
            end
            // request taken when the offered tag was non-zero
            if (proc2mem_command != mem_bus_pkg::BUS_NONE && mem2proc_response != '0) begin
                if (proc2mem_command == mem_bus_pkg::BUS_STORE) begin
                    blocks[proc2mem_addr[31:3]] = proc2mem_data;
                end else begin
                    pending      = 1'b1;
                    pending_tag  = mem2proc_response;
                    pending_addr = proc2mem_addr;
                    countdown    = LATENCY_MIN + int'($unsigned($random(seed)) % LATENCY_SPAN);
                end
                // tags 1 to 15 in rotation
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            roll = int'($unsigned($random(seed)) % 100);
            mem2proc_response <= (roll < refuse_percent) ? '0 : next_tag;
        end
    end

endmodule

/* dv/pipeline_front_tb.sv */
module pipeline_front_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // cycles any single wait may take
    localparam int WAIT_LIMIT = 2000;
    localparam int FIRST_FETCHES = 16;

    logic                                clock;
    logic                                reset;
    logic [mem_bus_pkg::MEM_TAG_W-1:0]   mem2proc_response;
    logic [mem_bus_pkg::MEM_BLOCK_W-1:0] mem2proc_data;
    logic [mem_bus_pkg::MEM_TAG_W-1:0]   mem2proc_tag;
    mem_bus_pkg::bus_command_t           proc2mem_command;
    logic [core_pkg::XLEN-1:0]           proc2mem_addr;
    logic [mem_bus_pkg::MEM_BLOCK_W-1:0] proc2mem_data;
    mem_bus_pkg::mem_size_t              proc2mem_size;
    mem_bus_pkg::bus_command_t           dmem_command;
    logic [core_pkg::XLEN-1:0]           dmem_addr;
    logic [mem_bus_pkg::MEM_BLOCK_W-1:0] dmem_wdata;
    logic                                dmem_grant;
    logic                                dmem_valid;
    logic [mem_bus_pkg::MEM_BLOCK_W-1:0] dmem_data;
    logic                                if_valid;
    logic [core_pkg::XLEN-1:0]           if_pc;
    logic [core_pkg::INST_W-1:0]         if_inst;
    int                                  refuse_percent;

    int seed = 29107;
    int errors = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int fetch_count = 0;
    int loads_checked = 0;
    int accept_count = 0;
    int request_count = 0;
    logic [core_pkg::XLEN-1:0] expected_pc = core_pkg::RESET_PC;

    // shadow of every store, and expected data of granted loads in order
    logic [63:0] shadow [logic [28:0]];
    logic [63:0] pending_loads [$];

    pipeline_front UUT (.*);

    mem_model mem_model_0 (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // unwritten block, two words built from the block address
    function automatic logic [63:0] reference_block(input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] lo;
        logic [31:0] hi;
        base = {addr[31:3], 3'b000};
        lo   = (base * 32'h9E37_79B9) ^ 32'h1357_9BDF;
        hi   = ((base + 32'd4) * 32'h9E37_79B9) ^ 32'h2468_ACE0;
        return {hi, lo};
    endfunction

    function automatic logic [63:0] expected_data(input logic [31:0] addr);
        if (shadow.exists(addr[31:3])) begin
            return shadow[addr[31:3]];
        end
        return reference_block(addr);
    endfunction

    // pc bit 2 picks the word
    function automatic logic [31:0] expected_inst(input logic [31:0] pc);
        logic [63:0] block;
        block = expected_data(pc);
        return pc[2] ? block[63:32] : block[31:0];
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        assert (got === expected) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checker, mid cycle where outputs are stable
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset && if_valid) begin
            compare_value("if_pc", 64'(if_pc), 64'(expected_pc));
            compare_value("if_inst", 64'(if_inst), 64'(expected_inst(expected_pc)));
            expected_pc = expected_pc + core_pkg::PC_STEP;
            fetch_count++;
        end
        if (!reset && dmem_valid) begin
            assert (pending_loads.size() != 0) else begin
                $display("load data arrived while no load was outstanding");
                errors++;
            end
            if (pending_loads.size() != 0) begin
                compare_value("dmem_data", dmem_data, pending_loads.pop_front());
                loads_checked++;
            end
        end
    end

    // bus as memory sees it just before the edge
    always @(posedge clock) begin
        if (!reset && proc2mem_command != mem_bus_pkg::BUS_NONE) begin
            compare_value("proc2mem_size", 64'(proc2mem_size), 64'(mem_bus_pkg::DOUBLE));
        end
        // memory taking the held data request, counted apart from dmem_grant
        if (!reset && dmem_command != mem_bus_pkg::BUS_NONE
                && proc2mem_command == dmem_command
                && proc2mem_addr == dmem_addr
                && mem2proc_response != '0) begin
            accept_count++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // hold the request until granted, then drop it
    task automatic issue_request(input mem_bus_pkg::bus_command_t command,
                                 input logic [31:0] addr, input logic [63:0] wdata);
        int   waited;
        logic granted;
        waited  = 0;
        granted = 1'b0;
        @(negedge clock);
        dmem_command = command;
        dmem_addr    = addr;
        dmem_wdata   = wdata;
        request_count++;
        while (!granted && waited < WAIT_LIMIT) begin
            @(posedge clock);
            granted = dmem_grant;
            waited++;
        end
        if (granted && command == mem_bus_pkg::BUS_STORE) begin
            shadow[addr[31:3]] = wdata;
        end else if (granted) begin
            pending_loads.push_back(expected_data(addr));
        end else begin
            $display("timeout: data request to %h was never granted", addr);
            errors++;
        end
        @(negedge clock);
        dmem_command = mem_bus_pkg::BUS_NONE;
    endtask

    task automatic drain_loads();
        int waited;
        waited = 0;
        while (pending_loads.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (pending_loads.size() != 0) begin
            $display("timeout: %0d load replies never arrived", pending_loads.size());
            errors++;
        end
    endtask

    task automatic wait_fetches(input int target);
        int waited;
        waited = 0;
        while (fetch_count < target && waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (fetch_count < target) begin
            $display("timeout: only %0d of %0d fetches arrived", fetch_count, target);
            errors++;
        end
    endtask

    // loads and stores over 32 blocks, away from the fetch region
    task automatic run_mix(input int count);
        logic [31:0] pick;
        logic [31:0] addr;
        for (int i = 0; i < count; i++) begin
            pick = $random(seed);
            addr = {24'h000100, pick[4:0], 3'b000};
            if (pick[8]) begin
                issue_request(mem_bus_pkg::BUS_STORE, addr, {$random(seed), $random(seed)});
            end else begin
                issue_request(mem_bus_pkg::BUS_LOAD, addr, 64'h0);
            end
            // idle gap so fetch gets the port too
            repeat (int'(pick[11:9])) @(negedge clock);
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - mark);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          mark;
        int          fetch_mark;
        int          accept_mark;
        int          request_mark;
        logic [63:0] store_value;
        reset          = 1'b1;
        dmem_command   = mem_bus_pkg::BUS_NONE;
        dmem_addr      = '0;
        dmem_wdata     = '0;
        refuse_percent = 0;
        mark           = errors;
        repeat (10) @(negedge clock);
        compare_value("if_valid", 64'(if_valid), 64'h0);
        compare_value("dmem_valid", 64'(dmem_valid), 64'h0);
        compare_value("dmem_grant", 64'(dmem_grant), 64'h0);
        compare_value("proc2mem_command", 64'(proc2mem_command), 64'h0);
        reset = 1'b0;

        wait_fetches(FIRST_FETCHES);
        finish_test("fetch stream after reset", mark);

        mark = errors;
        issue_request(mem_bus_pkg::BUS_LOAD, 32'h0001_0080, 64'h0);
        issue_request(mem_bus_pkg::BUS_LOAD, 32'h0000_0100, 64'h0);
        issue_request(mem_bus_pkg::BUS_LOAD, 32'hFFFF_FFF8, 64'h0);
        drain_loads();
        finish_test("plain loads", mark);

        mark = errors;
        store_value = {$random(seed), $random(seed)};
        issue_request(mem_bus_pkg::BUS_STORE, 32'h0001_0020, store_value);
        issue_request(mem_bus_pkg::BUS_LOAD, 32'h0001_0020, 64'h0);
        issue_request(mem_bus_pkg::BUS_LOAD, 32'h0001_0028, 64'h0);
        drain_loads();
        finish_test("store then load", mark);

        mark       = errors;
        fetch_mark = fetch_count;
        run_mix(24);
        drain_loads();
        wait_fetches(fetch_mark + 8);
        finish_test("data mixed with fetch", mark);

        // memory now refuses about half the requests
        mark           = errors;
        refuse_percent = 50;
        fetch_mark     = fetch_count;
        accept_mark    = accept_count;
        request_mark   = request_count;
        run_mix(30);
        drain_loads();
        wait_fetches(fetch_mark + 8);
        compare_value("data accept count", 64'(accept_count - accept_mark),
                      64'(request_count - request_mark));
        finish_test("random refusals", mark);

        $display("%0d tests, %0d with errors, %0d fetches, %0d loads, %0d errors",
                 tests_run, tests_bad, fetch_count, loads_checked, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/mem_bus_pkg.sv
hdl/core_pkg.sv
hdl/fetch_stage.sv
hdl/mem_arbiter.sv
hdl/pipeline_front.sv
dv/mem_model.sv
dv/pipeline_front_tb.sv

/* Makefile */
# Verilator build and run of the pipeline front end testbench

VERILATOR  := verilator
TOP        := pipeline_front_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ALL CHECKS PASSED
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
